/* include/conv_layer_cfg.svh */
`ifndef CONV_LAYER_CFG_SVH
`define CONV_LAYER_CFG_SVH

// image is square, width equals height
`define CONV_IMG_W 6

// channels packed into one pixel word
`define CONV_IN_CH 2

// output channels computed in parallel
`define CONV_OUT_CH 2

// signed fixed point word
`define CONV_WORD_W 16
`define CONV_FRAC_BITS 8

// line delay plus the three window registers span one image row
`define CONV_LINE_DEPTH (`CONV_IMG_W - 3)

`endif

/* logic/conv_layer_pkg.sv */
`include "conv_layer_cfg.svh"

package conv_layer_pkg;

	// one signed fixed point value
	typedef logic signed [`CONV_WORD_W-1:0] word_t;

	// lane i holds input channel i, also used for one weight word
	typedef word_t [`CONV_IN_CH-1:0] pixel_t;

	// row, column or memory address
	typedef logic [15:0] coord_t;

	// lane o holds output channel o
	typedef word_t [`CONV_OUT_CH-1:0] out_vec_t;

	// 3x3 window
	localparam int NUM_TAPS = 9;

	localparam int NUM_WEIGHTS = NUM_TAPS * `CONV_OUT_CH;

endpackage

/* logic/coef_loader.sv */
`timescale 1ns/1ps

module coef_loader import conv_layer_pkg::*; #(
	parameter type payload_t = pixel_t,
	parameter int  COUNT = NUM_WEIGHTS
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  payload_t data,
	output logic     read_strobe,
	output coord_t   read_addr,
	output payload_t coefs [COUNT]
);

	localparam coord_t LAST = coord_t'(COUNT - 1);

	typedef enum logic [1:0] {
		L_IDLE,
		L_LOAD,
		L_HELD
	} state_t;

	state_t state;
	logic   data_valid;
	logic   shift_en;
	coord_t shift_cnt;

	// memory answers one cycle after each strobe
	assign shift_en = data_valid && (state == L_LOAD);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= L_IDLE;
			read_strobe <= 1'b0;
			read_addr <= '0;
			data_valid <= 1'b0;
			shift_cnt <= '0;
		end
		else
		begin
			data_valid <= read_strobe;
			case (state)
				L_IDLE:
				begin
					if (start)
					begin
						state <= L_LOAD;
						read_strobe <= 1'b1;
						read_addr <= '0;
						shift_cnt <= '0;
					end
				end
				L_LOAD:
				begin
					if (read_strobe)
					begin
						if (read_addr == LAST)
						begin
							read_strobe <= 1'b0;
						end
						else
						begin
							read_addr <= read_addr + 1'b1;
						end
					end
					if (data_valid)
					begin
						if (shift_cnt == LAST)
						begin
							state <= L_HELD;
						end
						else
						begin
							shift_cnt <= shift_cnt + 1'b1;
						end
					end
				end
				default:
				begin
					// loaded once per reset
					read_strobe <= 1'b0;
				end
			endcase
		end
	end

	// new word enters at the top, so coefs[a] ends up holding address a
	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			coefs[COUNT - 1] <= data;
			for (int i = 0; i < COUNT - 1; i++)
			begin
				coefs[i] <= coefs[i + 1];
			end
		end
	end

	a_no_reload: assert property (
		@(posedge clk) disable iff (rst)
		(state == L_HELD) |-> !start
	);

endmodule

/* logic/window_line_buffer.sv */
`timescale 1ns/1ps
`include "conv_layer_cfg.svh"

module window_line_buffer import conv_layer_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  pixel_t pixel_data,
	output pixel_t taps [NUM_TAPS]
);

	localparam int DEPTH = `CONV_LINE_DEPTH;

	// middle row delay, then top row delay
	pixel_t mid_line [DEPTH];
	pixel_t top_line [DEPTH];

	// taps 6..8 bottom row, 3..5 middle, 0..2 top; higher index is newer
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				taps[i] <= '0;
			end
		end
		else
		begin
			taps[8] <= pixel_data;
			taps[5] <= mid_line[0];
			taps[2] <= top_line[0];
			for (int r = 0; r < 3; r++)
			begin
				taps[3 * r] <= taps[3 * r + 1];
				taps[3 * r + 1] <= taps[3 * r + 2];
			end
		end
	end

	// each line delay takes the oldest tap of the row below
	always_ff @(posedge clk)
	begin
		mid_line[DEPTH - 1] <= taps[6];
		top_line[DEPTH - 1] <= taps[3];
		for (int i = 0; i < DEPTH - 1; i++)
		begin
			mid_line[i] <= mid_line[i + 1];
			top_line[i] <= top_line[i + 1];
		end
	end

endmodule

/* logic/conv_mac_array.sv */
`timescale 1ns/1ps
`include "conv_layer_cfg.svh"

module conv_mac_array import conv_layer_pkg::*; (
	input  pixel_t   taps [NUM_TAPS],
	input  pixel_t   weights [NUM_WEIGHTS],
	input  word_t    biases [`CONV_OUT_CH],
	output out_vec_t result
);

	localparam int PROD_W = 2 * `CONV_WORD_W;
	localparam int OUT_CH = `CONV_OUT_CH;

	always_comb
	begin
		logic signed [PROD_W-1:0] prod;
		word_t pix_lane;
		word_t wgt_lane;
		word_t acc;
		int widx;

		for (int o = 0; o < OUT_CH; o++)
		begin
			acc = biases[o];
			for (int t = 0; t < NUM_TAPS; t++)
			begin
				// channels are stored highest first within each tap
				widx = t * OUT_CH + (OUT_CH - 1 - o);
				for (int i = 0; i < `CONV_IN_CH; i++)
				begin
					pix_lane = taps[t][i];
					wgt_lane = weights[widx][i];
					prod = pix_lane * wgt_lane;
					// rescale to the word format, sum wraps at word width
					acc = acc + word_t'(prod >>> `CONV_FRAC_BITS);
				end
			end
			result[o] = acc;
		end
	end

endmodule

/* logic/conv_scheduler.sv */
`timescale 1ns/1ps
`include "conv_layer_cfg.svh"

module conv_scheduler import conv_layer_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   pixel_store_done,
	output logic   read_pixel,
	output coord_t read_row,
	output coord_t read_col,
	output logic   save_enable,
	output coord_t output_row,
	output coord_t output_col,
	output logic   layer_done
);

	localparam int W = `CONV_IMG_W;

	// 2*W+2 slots from the read of pixel (r, c) to the read of (r+2, c+2)
	// plus one cycle of memory latency and one cycle into the window registers
	localparam int LATENCY = 2 * W + 4;

	localparam coord_t PIX_LAST = coord_t'(W - 1);
	localparam coord_t WIN_LAST = coord_t'(W - 3);
	localparam coord_t LAT_LAST = coord_t'(LATENCY - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DRAIN
	} state_t;

	state_t state;
	logic   start;
	logic   save_active;
	coord_t lat_cnt;

	assign start = (state == S_IDLE) && pixel_store_done;

	// columns past W-3 belong to windows that wrap into the next line
	assign save_enable = save_active && (output_col <= WIN_LAST);
	assign layer_done = save_enable && (output_row == WIN_LAST) && (output_col == WIN_LAST);

	// state and raster read counters
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			read_pixel <= 1'b0;
			read_row <= '0;
			read_col <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						state <= S_RUN;
						read_pixel <= 1'b1;
						read_row <= '0;
						read_col <= '0;
					end
				end
				S_RUN:
				begin
					if (read_col == PIX_LAST)
					begin
						read_col <= '0;
						if (read_row == PIX_LAST)
						begin
							read_pixel <= 1'b0;
							state <= S_DRAIN;
						end
						else
						begin
							read_row <= read_row + 1'b1;
						end
					end
					else
					begin
						read_col <= read_col + 1'b1;
					end
				end
				S_DRAIN:
				begin
					if (layer_done)
					begin
						state <= S_IDLE;
					end
				end
				default:
				begin
					state <= S_IDLE;
					read_pixel <= 1'b0;
				end
			endcase
		end
	end

	// save counters trail the reads by LATENCY cycles
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			lat_cnt <= '0;
			save_active <= 1'b0;
			output_row <= '0;
			output_col <= '0;
		end
		else if (start)
		begin
			lat_cnt <= '0;
			output_row <= '0;
			output_col <= '0;
		end
		else if (save_active)
		begin
			if (layer_done)
			begin
				save_active <= 1'b0;
			end
			else if (output_col == PIX_LAST)
			begin
				output_col <= '0;
				output_row <= output_row + 1'b1;
			end
			else
			begin
				output_col <= output_col + 1'b1;
			end
		end
		else if (state != S_IDLE)
		begin
			if (lat_cnt == LAT_LAST)
			begin
				save_active <= 1'b1;
			end
			else
			begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	// saved windows stay inside the image in both directions
	a_save_in_range: assert property (
		@(posedge clk) disable iff (rst)
		save_enable |-> (output_row <= WIN_LAST) && (output_col <= WIN_LAST)
	);

endmodule

/* logic/conv_layer_top.sv */
`timescale 1ns/1ps
`include "conv_layer_cfg.svh"

module conv_layer_top import conv_layer_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     pixel_store_done,
	input  logic     weight_store_done,
	input  logic     bias_store_done,
	input  pixel_t   pixel_data,
	input  pixel_t   weight_data,
	input  word_t    bias_data,
	output logic     read_pixel,
	output coord_t   read_row,
	output coord_t   read_col,
	output logic     read_weight,
	output coord_t   read_weight_addr,
	output logic     read_bias,
	output coord_t   read_bias_addr,
	output logic     save_enable,
	output coord_t   output_row,
	output coord_t   output_col,
	output out_vec_t output_data,
	output logic     layer_done
);

	pixel_t taps [NUM_TAPS];
	pixel_t weights [NUM_WEIGHTS];
	word_t  biases [`CONV_OUT_CH];

	conv_scheduler u_scheduler (
		.clk              (clk),
		.rst              (rst),
		.pixel_store_done (pixel_store_done),
		.read_pixel       (read_pixel),
		.read_row         (read_row),
		.read_col         (read_col),
		.save_enable      (save_enable),
		.output_row       (output_row),
		.output_col       (output_col),
		.layer_done       (layer_done)
	);

	window_line_buffer u_window (
		.clk        (clk),
		.rst        (rst),
		.pixel_data (pixel_data),
		.taps       (taps)
	);

	coef_loader #(
		.payload_t (pixel_t),
		.COUNT     (NUM_WEIGHTS)
	) u_weight_loader (
		.clk         (clk),
		.rst         (rst),
		.start       (weight_store_done),
		.data        (weight_data),
		.read_strobe (read_weight),
		.read_addr   (read_weight_addr),
		.coefs       (weights)
	);

	coef_loader #(
		.payload_t (word_t),
		.COUNT     (`CONV_OUT_CH)
	) u_bias_loader (
		.clk         (clk),
		.rst         (rst),
		.start       (bias_store_done),
		.data        (bias_data),
		.read_strobe (read_bias),
		.read_addr   (read_bias_addr),
		.coefs       (biases)
	);

	conv_mac_array u_mac (
		.taps    (taps),
		.weights (weights),
		.biases  (biases),
		.result  (output_data)
	);

endmodule

/* tb/tb_conv_layer.sv */
`timescale 1ns/1ps
`include "conv_layer_cfg.svh"

module tb_conv_layer import conv_layer_pkg::*; ();

	localparam int W = `CONV_IMG_W;
	localparam int NWIN = (W - 2) * (W - 2);
	localparam int BIAS_BASE = NUM_WEIGHTS;
	localparam int PIX_BASE = BIAS_BASE + `CONV_OUT_CH;
	localparam int EXP_BASE = PIX_BASE + W * W;
	localparam int STIM_LEN = EXP_BASE + NWIN;
	localparam int WAIT_LIMIT = 600;

	logic     clk;
	logic     rst;
	logic     pixel_store_done;
	logic     weight_store_done;
	logic     bias_store_done;
	pixel_t   pixel_data;
	pixel_t   weight_data;
	word_t    bias_data;
	logic     read_pixel;
	coord_t   read_row;
	coord_t   read_col;
	logic     read_weight;
	coord_t   read_weight_addr;
	logic     read_bias;
	coord_t   read_bias_addr;
	logic     save_enable;
	coord_t   output_row;
	coord_t   output_col;
	out_vec_t output_data;
	logic     layer_done;

	// weights, biases, pixels, expected outputs
	logic [31:0] stim [STIM_LEN];

	int tests_run;
	int tests_failed;

	conv_layer_top dut0 (
		.clk               (clk),
		.rst               (rst),
		.pixel_store_done  (pixel_store_done),
		.weight_store_done (weight_store_done),
		.bias_store_done   (bias_store_done),
		.pixel_data        (pixel_data),
		.weight_data       (weight_data),
		.bias_data         (bias_data),
		.read_pixel        (read_pixel),
		.read_row          (read_row),
		.read_col          (read_col),
		.read_weight       (read_weight),
		.read_weight_addr  (read_weight_addr),
		.read_bias         (read_bias),
		.read_bias_addr    (read_bias_addr),
		.save_enable       (save_enable),
		.output_row        (output_row),
		.output_col        (output_col),
		.output_data       (output_data),
		.layer_done        (layer_done)
	);

	always #5 clk = ~clk;

	// memories answer each read strobe one cycle later
	always @(posedge clk)
	begin
		logic   w_rd;
		logic   b_rd;
		logic   p_rd;
		coord_t w_addr;
		coord_t b_addr;
		coord_t p_row;
		coord_t p_col;

		w_rd = read_weight;
		b_rd = read_bias;
		p_rd = read_pixel;
		w_addr = read_weight_addr;
		b_addr = read_bias_addr;
		p_row = read_row;
		p_col = read_col;
		#1;
		if (w_rd)
		begin
			weight_data = stim[w_addr];
		end
		if (b_rd)
		begin
			bias_data = stim[BIAS_BASE + b_addr][15:0];
		end
		if (p_rd)
		begin
			pixel_data = stim[PIX_BASE + p_row * W + p_col];
		end
	end

	function automatic logic any_strobe();
		return read_pixel | read_weight | read_bias | save_enable | layer_done;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("mismatch %s expected %h actual %h", name, exp, act);
	endtask

	task automatic finish_test(input string name, input int errs);
		tests_run++;
		if (errs > 0)
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
		else
		begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic check_reset_quiet();
		int errs;

		errs = 0;
		for (int i = 0; i < 24; i++)
		begin
			@(posedge clk);
			if (any_strobe())
			begin
				$display("reset_quiet: a strobe output is high before any start");
				errs++;
			end
			if (i == 15)
			begin
				#1 rst = 1'b0;
			end
		end
		finish_test("reset_quiet", errs);
	endtask

	task automatic check_coef_load(input string name, input bit is_bias, input int count);
		int   errs;
		int   waited;
		int   seen;
		logic strobe;
		coord_t addr;

		errs = 0;
		waited = 0;
		seen = 0;
		@(posedge clk);
		#1;
		if (is_bias)
			bias_store_done = 1'b1;
		else
			weight_store_done = 1'b1;
		@(posedge clk);
		#1;
		bias_store_done = 1'b0;
		weight_store_done = 1'b0;
		strobe = 1'b0;
		while (!strobe && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			strobe = is_bias ? read_bias : read_weight;
			waited++;
		end
		if (!strobe)
		begin
			$display("%s: timed out waiting for the read strobe", name);
			errs++;
		end
		while (strobe && seen < count + 4)
		begin
			addr = is_bias ? read_bias_addr : read_weight_addr;
			if (addr != coord_t'(seen))
			begin
				report_mismatch(name, seen, addr);
				errs++;
			end
			seen++;
			@(posedge clk);
			strobe = is_bias ? read_bias : read_weight;
		end
		if (seen != count)
		begin
			report_mismatch(name, count, seen);
			errs++;
		end
		repeat (8)
		begin
			@(posedge clk);
			if (read_bias || read_weight)
			begin
				$display("%s: read strobe rose again after the last address", name);
				errs++;
			end
		end
		finish_test(name, errs);
	endtask

	task automatic run_image(input string name);
		int errs;
		int n_read;
		int n_save;
		int n_done;
		int cyc;

		errs = 0;
		n_read = 0;
		n_save = 0;
		n_done = 0;
		cyc = 0;
		@(posedge clk);
		#1 pixel_store_done = 1'b1;
		@(posedge clk);
		#1 pixel_store_done = 1'b0;
		while (n_done == 0 && cyc < WAIT_LIMIT)
		begin
			@(posedge clk);
			cyc++;
			if (read_pixel)
			begin
				if (read_row != coord_t'(n_read / W) || read_col != coord_t'(n_read % W))
				begin
					report_mismatch(name, {16'(n_read / W), 16'(n_read % W)},
						{read_row, read_col});
					errs++;
				end
				n_read++;
			end
			if (save_enable)
			begin
				if (output_row != coord_t'(n_save / (W - 2))
					|| output_col != coord_t'(n_save % (W - 2)))
				begin
					report_mismatch(name, {16'(n_save / (W - 2)), 16'(n_save % (W - 2))},
						{output_row, output_col});
					errs++;
				end
				if (n_save < NWIN && output_data != stim[EXP_BASE + n_save])
				begin
					report_mismatch(name, stim[EXP_BASE + n_save], output_data);
					errs++;
				end
				n_save++;
			end
			if (layer_done)
			begin
				n_done++;
				if (!save_enable)
				begin
					$display("%s: layer_done came without save_enable", name);
					errs++;
				end
			end
		end
		if (n_done == 0)
		begin
			$display("%s: timed out waiting for layer_done", name);
			errs++;
		end
		else if (n_save != NWIN)
		begin
			report_mismatch(name, NWIN, n_save);
			errs++;
		end
		if (n_read != W * W)
		begin
			report_mismatch(name, W * W, n_read);
			errs++;
		end
		repeat (20)
		begin
			@(posedge clk);
			if (any_strobe())
			begin
				$display("%s: a strobe fired after layer_done", name);
				errs++;
			end
		end
		finish_test(name, errs);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		pixel_store_done = 1'b0;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_data = '0;
		weight_data = '0;
		bias_data = '0;
		tests_run = 0;
		tests_failed = 0;
		$readmemh("tb/conv_stimulus.txt", stim);

		check_reset_quiet();
		check_coef_load("weight_load", 1'b0, NUM_WEIGHTS);
		check_coef_load("bias_load", 1'b1, `CONV_OUT_CH);
		run_image("image_first");
		// same image again with the held coefficients
		run_image("image_second");

		$display("tests %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0)
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb/conv_stimulus.txt */
// 18 weight words {lane1,lane0}, 2 biases, 36 pixels {lane1,lane0} raster order
// then 16 expected outputs {ch1,ch0} raster order over the valid windows
0000FF00
00000100
00000000
00000100
00000000
00000100
00000000
00000100
02000000
00000100
00000000
00000100
00000000
00000100
00000000
00000100
00000000
00000100
00000010
0000FF9C
00200000
00210001
00220002
00230003
00240004
00250005
00300008
00310009
0032000A
0033000B
0034000C
0035000D
00400010
00410011
00420012
00430013
00440014
00450015
00500018
00510019
0052001A
0053001B
0054001C
0055001D
00600020
00610021
00620022
00630023
00640024
00650025
00700028
00710029
0072002A
0073002B
0074002C
0075002D
FFFE0061
FFFF006A
00000073
0001007C
001600A9
001700B2
001800BB
001900C4
002E00F1
002F00FA
00300103
0031010C
00460139
00470142
0048014B
00490154

/* sim.f */
+incdir+include
logic/conv_layer_pkg.sv
logic/coef_loader.sv
logic/window_line_buffer.sv
logic/conv_mac_array.sv
logic/conv_scheduler.sv
logic/conv_layer_top.sv
tb/tb_conv_layer.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_conv_layer
FLIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
